/* rtl/mul_macros.svh */
/*
 * Booth multiplier sizing: operand, product and step counter widths.
 */
`ifndef MUL_MACROS_SVH
`define MUL_MACROS_SVH

// **************************************************
// Operand and product widths
// **************************************************
`define MUL_WIDTH        16                  // Signed operand width, even.
`define MUL_PROD_WIDTH   (2 * `MUL_WIDTH)    // Full signed product.

// **************************************************
// Iteration control
// **************************************************
`define MUL_STEPS        `MUL_WIDTH          // One radix-2 step per multiplier bit.
`define MUL_CNT_WIDTH    5                   // Must hold MUL_STEPS.

`endif

/* rtl/mul_data_pkg.sv */
/*
 * Booth datapath types: step operation and the accumulator/multiplier shift word.
 */
package mul_data_pkg;

`include "mul_macros.svh"

    // Operation applied to acc on one Booth step.
    typedef enum logic [1:0] {
        BOOTH_NOP = 2'b00,                       // Pair 00 or 11.
        BOOTH_ADD = 2'b01,                       // Pair 01.
        BOOTH_SUB = 2'b10                        // Pair 10.
    } booth_op_t;

    // **************************************************
    // Shift word
    // **************************************************
    typedef struct packed {
        logic [`MUL_WIDTH-1:0] acc;              // Upper product half.
        logic [`MUL_WIDTH-1:0] mq;               // Multiplier, lower product half.
        logic                  q_m1;             // Bit shifted out of mq.
    } shift_fields_t;

    // Read as fields for the add, as one word for the shift.
    typedef union packed {
        shift_fields_t             fields;
        logic [2*`MUL_WIDTH:0]     whole;
    } shift_word_t;

endpackage

/* rtl/mul_ctrl_pkg.sv */
/*
 * Booth controller types.
 */
package mul_ctrl_pkg;

    // Handshake and iteration states.
    typedef enum logic [1:0] {
        ST_IDLE   = 2'b00,                       // Waiting for an operand pair.
        ST_BOOTH  = 2'b01,                       // Stepping the datapath.
        ST_OUTPUT = 2'b10                        // Holding the product.
    } mul_state_t;

endpackage

/* rtl/mul_ctrl_if.sv */
/*
 * Control and status link between the Booth controller and datapath.
 */
`timescale 1ns/1ps

interface mul_ctrl_if
    import mul_data_pkg::*;
();

    // Controller to datapath.
    logic      load;                             // Capture operands, clear acc and counter.
    logic      step;                             // Perform one Booth iteration.
    booth_op_t op;                               // Operation for this step.

    // Datapath to controller.
    logic [1:0] q_pair;                          // {mq[0], q_m1}.
    logic       last_step;                       // Final iteration in progress.

    modport ctrl_mp (
        output load,
        output step,
        output op,
        input  q_pair,
        input  last_step
    );

    modport dp_mp (
        input  load,
        input  step,
        input  op,
        output q_pair,
        output last_step
    );

endinterface

/* rtl/mul_ctrl.sv */
/*
 * Booth multiplier controller: valid/ready handshakes on both sides,
 * sequencing of the datapath steps and radix-2 recoding of the bit pair.
 */
`timescale 1ns/1ps

module mul_ctrl
    import mul_ctrl_pkg::*;
    import mul_data_pkg::*;
(
    input  logic            clk,
    input  logic            rst,
    input  logic            src_valid,
    output logic            src_ready,
    input  logic            dest_ready,
    output logic            dest_valid,
    mul_ctrl_if.ctrl_mp     cif
);

    mul_state_t state;
    mul_state_t state_next;

    // **************************************************
    // State register
    // **************************************************
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            state <= ST_IDLE;
        end else begin
            state <= state_next;
        end
    end

    // **************************************************
    // Next state
    // **************************************************
    always_comb begin
        state_next = state;
        case (state)
            ST_IDLE: begin
                if (src_valid) begin
                    state_next = ST_BOOTH;               // Operands taken this edge.
                end
            end
            ST_BOOTH: begin
                if (cif.last_step) begin
                    state_next = ST_OUTPUT;
                end
            end
            ST_OUTPUT: begin
                if (dest_ready) begin
                    state_next = ST_IDLE;                // Product consumed.
                end
            end
            default: begin
                state_next = ST_IDLE;
            end
        endcase
    end

    // Handshake outputs come straight from the state.
    assign src_ready  = (state == ST_IDLE);
    assign dest_valid = (state == ST_OUTPUT);

    // Datapath strobes.
    assign cif.load = (state == ST_IDLE) && src_valid;
    assign cif.step = (state == ST_BOOTH);

    // **************************************************
    // Booth recoding
    // **************************************************
    // The pair is {current multiplier bit, previous multiplier bit}.
    always_comb begin
        case (cif.q_pair)
            2'b10: begin
                cif.op = BOOTH_SUB;                      // Start of a run of ones.
            end
            2'b01: begin
                cif.op = BOOTH_ADD;                      // End of a run of ones.
            end
            default: begin
                cif.op = BOOTH_NOP;
            end
        endcase
    end

    // **************************************************
    // Checks
    // **************************************************
    // A product offered to the consumer is withdrawn only once taken.
    a_dest_valid_held: assert property (
        @(posedge clk) disable iff (!rst)
        (dest_valid && !dest_ready) |=> dest_valid
    ) else $error("dest_valid dropped without dest_ready");

endmodule

/* rtl/mul_datapath.sv */
/*
 * Booth multiplier datapath: multiplicand register, acc add/subtract,
 * arithmetic shift of the acc/mq word and the step counter.
 */
`timescale 1ns/1ps

`include "mul_macros.svh"

module mul_datapath
    import mul_data_pkg::*;
(
    input  logic                               clk,
    input  logic                               rst,
    input  logic signed [`MUL_WIDTH-1:0]       multiplicand,
    input  logic signed [`MUL_WIDTH-1:0]       multiplier,
    output logic signed [`MUL_PROD_WIDTH-1:0]  product,
    mul_ctrl_if.dp_mp                          cif
);

    localparam int W = `MUL_WIDTH;
    localparam logic [`MUL_CNT_WIDTH-1:0] LAST_CNT = `MUL_CNT_WIDTH'(`MUL_STEPS - 1);

    logic [W-1:0]                mcand;         // Captured multiplicand.
    shift_word_t                 sw;            // acc, mq, q_m1.
    shift_word_t                 sw_add;        // After the add, before the shift.
    shift_word_t                 sw_next;
    logic [W:0]                  acc_sum;       // acc with a guard bit.
    logic [`MUL_CNT_WIDTH-1:0]   cnt;

    // **************************************************
    // Add / subtract on the struct view
    // **************************************************
    always_comb begin
        case (cif.op)
            BOOTH_ADD: begin
                acc_sum = {sw.fields.acc[W-1], sw.fields.acc} + {mcand[W-1], mcand};
            end
            BOOTH_SUB: begin
                acc_sum = {sw.fields.acc[W-1], sw.fields.acc} - {mcand[W-1], mcand};
            end
            default: begin
                acc_sum = {sw.fields.acc[W-1], sw.fields.acc};
            end
        endcase
    end

    always_comb begin
        sw_add            = sw;
        sw_add.fields.acc = acc_sum[W-1:0];
    end

    // **************************************************
    // Arithmetic shift on the whole-word view
    // **************************************************
    // The guard bit is the true sign, so subtracting -2**(W-1) still shifts right.
    always_comb begin
        sw_next.whole = {acc_sum[W], sw_add.whole[2*W:1]};
    end

    // Payload registers.
    always_ff @(posedge clk) begin
        if (cif.load) begin
            mcand        <= multiplicand;
            sw.fields.acc  <= '0;
            sw.fields.mq   <= multiplier;
            sw.fields.q_m1 <= 1'b0;
        end else if (cif.step) begin
            sw <= sw_next;
        end
    end

    // **************************************************
    // Step counter
    // **************************************************
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            cnt <= '0;
        end else if (cif.load) begin
            cnt <= '0;
        end else if (cif.step) begin
            cnt <= cnt + 1'b1;
        end
    end

    assign cif.last_step = cif.step && (cnt == LAST_CNT);
    assign cif.q_pair    = {sw.fields.mq[0], sw.fields.q_m1};

    assign product = {sw.fields.acc, sw.fields.mq};  // Valid once the last step is done.

    // **************************************************
    // Checks
    // **************************************************
    // Loading a new pair mid-iteration would corrupt the product.
    a_load_step_excl: assert property (
        @(posedge clk) disable iff (!rst)
        !(cif.load && cif.step)
    ) else $error("load and step high together");

    // Controller stops stepping right after the counter reports the last step.
    a_stop_after_last: assert property (
        @(posedge clk) disable iff (!rst)
        cif.last_step |=> !cif.step
    ) else $error("step still high after last_step");

endmodule

/* rtl/booth_mul_top.sv */
/*
 * 16-bit signed radix-2 Booth multiplier with valid/ready on both sides.
 */
`timescale 1ns/1ps

`include "mul_macros.svh"

module booth_mul_top (
    input  logic                               clk,
    input  logic                               rst,
    // Operand side.
    input  logic                               src_valid,
    output logic                               src_ready,
    input  logic signed [`MUL_WIDTH-1:0]       multiplicand,
    input  logic signed [`MUL_WIDTH-1:0]       multiplier,
    // Product side.
    output logic                               dest_valid,
    input  logic                               dest_ready,
    output logic signed [`MUL_PROD_WIDTH-1:0]  product
);

    // **************************************************
    // Controller to datapath link
    // **************************************************
    mul_ctrl_if cif ();

    mul_ctrl i_ctrl (
        .clk        (clk),
        .rst        (rst),
        .src_valid  (src_valid),
        .src_ready  (src_ready),
        .dest_ready (dest_ready),
        .dest_valid (dest_valid),
        .cif        (cif.ctrl_mp)
    );

    mul_datapath i_datapath (
        .clk          (clk),
        .rst          (rst),
        .multiplicand (multiplicand),
        .multiplier   (multiplier),
        .product      (product),
        .cif          (cif.dp_mp)
    );

endmodule

/* verification/tb_booth_mul.sv */
/*
 * Booth multiplier testbench: golden operand pairs with random source gaps,
 * consumer stalls, latency and hold checks on the valid/ready handshakes.
 */
`timescale 1ns/1ps

`include "mul_macros.svh"

module tb_booth_mul;

    localparam int NUM_VEC      = 26;
    localparam int CLK_PERIOD   = 20;
    localparam int RESET_CYCLES = 16;
    localparam int LATENCY      = `MUL_STEPS + 1;     // Edges, the accepting edge included.
    localparam int MAX_GAP      = 3;
    localparam int BURST_LEN    = 6;                  // Closing vectors sent back to back.

    logic                               clk;
    logic                               rst;
    logic                               src_valid;
    logic                               src_ready;
    logic signed [`MUL_WIDTH-1:0]       multiplicand;
    logic signed [`MUL_WIDTH-1:0]       multiplier;
    logic                               dest_valid;
    logic                               dest_ready;
    logic signed [`MUL_PROD_WIDTH-1:0]  product;

    // Four words per vector: multiplicand, multiplier, product, stall.
    logic [31:0] golden_mem [NUM_VEC*4];
    logic [31:0] lfsr_state = 32'h267b_1d18;
    bit          loaded     = 1'b0;
    int          watch_cycles;

    booth_mul_top i_dut (
        .clk          (clk),
        .rst          (rst),
        .src_valid    (src_valid),
        .src_ready    (src_ready),
        .multiplicand (multiplicand),
        .multiplier   (multiplier),
        .dest_valid   (dest_valid),
        .dest_ready   (dest_ready),
        .product      (product)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #(CLK_PERIOD / 2) clk = ~clk;
        end
    end

    // **************************************************
    // Helpers
    // **************************************************
    // x^32 + x^22 + x^2 + x + 1.
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task take_bits(input int n, output int value);
        int k;
        value = 0;
        for (k = 0; k < n; k++) begin
            lfsr_state = lfsr_next(lfsr_state);
            value      = (value << 1) | int'(lfsr_state[0]);
        end
    endtask

    task present_operands(input int idx);
        src_valid    <= 1'b1;
        multiplicand <= golden_mem[4*idx][`MUL_WIDTH-1:0];
        multiplier   <= golden_mem[4*idx+1][`MUL_WIDTH-1:0];
    endtask

    task check_value(input string name, input logic [31:0] actual, input logic [31:0] expected);
        if (actual !== expected) begin
            $display("[ERROR] %0t ns %s: got %h, expected %h", $time, name, actual, expected);
            $display("Testbench failed");
            $fatal(1, "Value mismatch.");
        end
    endtask

    // **************************************************
    // Watchdog
    // **************************************************
    initial begin
        wait (loaded);
        repeat (watch_cycles) @(posedge clk);
        $display("Timeout: the multiplier stopped producing results after %0d cycles.",
                 watch_cycles);
        $display("Testbench failed");
        $fatal(1, "Watchdog expired.");
    end

    // **************************************************
    // Stimulus and checks
    // **************************************************
    initial begin
        int          i;
        int          k;
        int          gap;
        int          stall;
        int          edges;
        int          max_stall;
        logic [31:0] held;
        bit          offered;

        rst          = 1'b0;
        src_valid    = 1'b0;
        multiplicand = '0;
        multiplier   = '0;
        dest_ready   = 1'b0;

        $readmemh("verification/mul_golden.txt", golden_mem);
        max_stall = 0;
        for (i = 0; i < NUM_VEC; i++) begin
            if (int'(golden_mem[4*i+3]) > max_stall) begin
                max_stall = int'(golden_mem[4*i+3]);
            end
        end
        watch_cycles = NUM_VEC * (LATENCY + MAX_GAP + max_stall + 4) + RESET_CYCLES;
        loaded       = 1'b1;

        repeat (RESET_CYCLES) @(posedge clk);
        rst <= 1'b1;
        @(negedge clk);
        check_value("src_ready", 32'(src_ready), 32'd1);
        check_value("dest_valid", 32'(dest_valid), 32'd0);
        @(posedge clk);

        offered = 1'b0;
        take_bits(2, gap);
        for (i = 0; i < NUM_VEC; i++) begin
            stall = int'(golden_mem[4*i+3]);
            if (!offered) begin
                repeat (gap) @(posedge clk);
                present_operands(i);
            end
            @(negedge clk);
            check_value("src_ready", 32'(src_ready), 32'd1);
            check_value("dest_valid", 32'(dest_valid), 32'd0);
            @(posedge clk);                               // Accepting edge.
            dest_ready <= (stall == 0);                   // Early ready must take nothing.

            // Next pair waits on src_valid during the iteration when its gap is zero.
            take_bits(2, gap);
            if (i >= NUM_VEC - BURST_LEN) begin
                gap = 0;
            end
            offered = (gap == 0) && (i + 1 < NUM_VEC);
            if (offered) begin
                present_operands(i + 1);
            end else begin
                src_valid <= 1'b0;
            end

            edges = 1;
            @(negedge clk);
            while (!dest_valid && edges <= LATENCY) begin
                check_value("src_ready", 32'(src_ready), 32'd0);
                @(posedge clk);
                edges++;
                @(negedge clk);
            end
            check_value("dest_valid latency", 32'(edges), 32'(LATENCY));
            check_value("src_ready", 32'(src_ready), 32'd0);
            check_value("product", product, golden_mem[4*i+2]);
            held = product;

            for (k = 0; k < stall; k++) begin
                @(posedge clk);
                if (k == stall - 1) begin
                    dest_ready <= 1'b1;
                end
                @(negedge clk);
                check_value("dest_valid", 32'(dest_valid), 32'd1);
                check_value("src_ready", 32'(src_ready), 32'd0);
                check_value("product", product, held);
            end
            @(posedge clk);                               // Product taken.
            dest_ready <= 1'b0;
        end

        @(negedge clk);
        check_value("dest_valid", 32'(dest_valid), 32'd0);
        check_value("src_ready", 32'(src_ready), 32'd1);

        $display("Testbench passed");
        $finish;
    end

endmodule

/* verification/mul_golden.txt */
// multiplicand multiplier product stall, all hex, one vector per line.
// Product is the signed 32-bit result, stall the cycles dest_ready stays low.
0000 0000 00000000 0
0001 0001 00000001 1
FFFF 0001 FFFFFFFF 2
FFFF FFFF 00000001 0
8000 8000 40000000 3
8000 7FFF C0008000 1
7FFF 8000 C0008000 0
7FFF 7FFF 3FFF0001 2
0000 8000 00000000 1
8000 0001 FFFF8000 0
0001 8000 FFFF8000 4
8000 FFFF 00008000 0
0064 FF9C FFFFD8F0 2
FF9C FF9C 00002710 0
1234 0005 00005B04 5
0005 FFFD FFFFFFF1 0
FFFD 0005 FFFFFFF1 1
00FF 00FF 0000FE01 0
0100 0100 00010000 3
AAAA 5555 E38E1C72 2
5555 5555 1C718E39 0
7FFF FFFF FFFF8001 1
FFFF 8000 00008000 0
0003 0007 00000015 0
FFF0 0010 FFFFFF00 6
4000 FFFE FFFF8000 0

/* tb.f */
+incdir+rtl
rtl/mul_data_pkg.sv
rtl/mul_ctrl_pkg.sv
rtl/mul_ctrl_if.sv
rtl/mul_ctrl.sv
rtl/mul_datapath.sv
rtl/booth_mul_top.sv
verification/tb_booth_mul.sv

/* Makefile */
SIM      = verilator
FLAGS    = --binary --timing --assert
TOP      = tb_booth_mul
FILELIST = tb.f
OBJ_DIR  = obj_dir
PASS_MSG = Testbench passed

.PHONY: sim clean

# Builds and runs, then fails unless the pass line was printed.
sim:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	@out=$$(./$(OBJ_DIR)/V$(TOP) 2>&1); \
	echo "$$out"; \
	echo "$$out" | grep -q "^$(PASS_MSG)$$"

clean:
	rm -rf $(OBJ_DIR)
